// File: all.f
+incdir+bench
source/arm_isa_pkg.sv
source/dp_ctrl_pkg.sv
source/regfile.sv
source/shifter.sv
source/alu.sv
source/datapath.sv
bench/datapath_tb.sv

// File: bench/datapath_model.svh
`ifndef DATAPATH_MODEL_SVH
`define DATAPATH_MODEL_SVH

// state the datapath should hold after each edge
word_t  m_regs [16];
pc_t    m_pc;
word_t  m_a;
word_t  m_b;
word_t  m_s;
flags_t m_status;

// combinational values of the current cycle
word_t  e_val_a;
word_t  e_val_b;
word_t  e_alu;
flags_t e_flags;

function automatic void model_reset();
    foreach (m_regs[i]) m_regs[i] = '0;
    m_pc     = '0;
    m_a      = '0;
    m_b      = '0;
    m_s      = '0;
    m_status = '0;
endfunction

function automatic word_t model_shift(word_t v, shift_op_e op, word_t amount);
    int unsigned n;
    n = amount % 32;
    case (op)
        LSL:     return v << n;
        LSR:     return v >> n;
        ASR:     return 32'({{32{v[31]}}, v} >> n);    // sign extended copy
        default: return (v >> n) | (v << (32 - n));    // ror, n of 0 gives v
    endcase
endfunction

function automatic word_t model_alu(word_t a, word_t b, alu_op_e op, output flags_t f);
    logic [32:0] wide;
    word_t       y;
    f = '0;
    case (op)
        ADD: begin
            wide = {1'b0, a} + {1'b0, b};
            y    = wide[31:0];
            f.c  = wide[32];
            f.v  = (a[31] == b[31]) && (y[31] != a[31]);
        end
        SUB: begin
            y   = a - b;
            f.c = (a >= b);     // no borrow
            f.v = (a[31] != b[31]) && (y[31] != a[31]);
        end
        RSB: begin
            y   = b - a;
            f.c = (b >= a);
            f.v = (a[31] != b[31]) && (y[31] != b[31]);
        end
        AND:     y = a & b;
        ORR:     y = a | b;
        EOR:     y = a ^ b;
        MOV:     y = b;
        default: y = ~b;        // mvn
    endcase
    f.n = y[31];
    f.z = (y == 32'd0);
    return y;
endfunction

function automatic void model_eval(dp_ctrl_t c);
    word_t imm;
    imm     = c.operands.sel_branch_imm ? c.operands.imm24 : c.operands.imm12;
    e_val_a = c.operands.zero_a ? 32'd0 : m_a;
    e_val_b = c.operands.sel_imm ? imm : model_shift(m_b, c.shift_op, m_s);
    e_alu   = model_alu(e_val_a, e_val_b, c.alu_op, e_flags);
endfunction

// next state at the coming edge, needs model_eval of the same cycle first
function automatic void model_step(dp_ctrl_t c, word_t lr);
    operand_ctrl_t o;
    word_t         a_in;
    word_t         b_in;
    word_t         s_in;
    o = c.operands;
    case (o.sel_a_in)
        FWD_ALU: a_in = e_alu;
        FWD_ALT: a_in = word_t'(m_pc);
        default: a_in = m_regs[o.a_addr];
    endcase
    case (o.sel_b_in)
        FWD_ALU: b_in = e_alu;
        FWD_ALT: b_in = e_val_b;
        default: b_in = m_regs[o.b_addr];
    endcase
    case (o.sel_s_in)
        FWD_ALU: s_in = e_alu;
        FWD_ALT: s_in = 32'd0;
        default: s_in = m_regs[o.s_addr];
    endcase
    if (o.en_a) m_a = a_in;
    if (o.en_b) m_b = b_in;
    if (o.en_s) m_s = o.sel_s_reg ? s_in : o.shift_imm;
    if (c.en_status && c.status_rdy) m_status = e_flags;
    if (c.pc.load) begin
        case (c.pc.sel)
            PC_NEXT:  m_pc = m_pc + 11'd1;
            PC_ALU:   m_pc = e_alu[10:0];
            PC_START: m_pc = c.pc.start;
            default:  ;
        endcase
    end
    // lowest priority first so the load port ends on top
    if (c.rf_wr.en) begin
        if (c.rf_wr.sel_lr) m_regs[LR_IDX] = lr;
        else m_regs[c.rf_wr.addr] = e_alu;
    end
    if (c.rf_wr.en2) m_regs[c.rf_wr.addr2] = e_alu;
    if (c.rf_wr.ldr_en) m_regs[c.rf_wr.ldr_addr] = c.rf_wr.ldr_data;
endfunction

`endif

// File: bench/datapath_tb.sv
`timescale 1ns/100ps

module datapath_tb import arm_isa_pkg::*, dp_ctrl_pkg::*; ();

    logic     clk;
    logic     arst_n;
    dp_ctrl_t ctrl;
    word_t    lr_in;
    word_t    result;
    word_t    status;
    word_t    str_data;
    pc_t      pc;
    int       cycle_no;

    `include "datapath_model.svh"

    datapath uut (
        .clk      (clk),
        .arst_n   (arst_n),
        .ctrl     (ctrl),
        .lr_in    (lr_in),
        .result   (result),
        .status   (status),
        .str_data (str_data),
        .pc       (pc)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "datapath run stopped at first error");
    endtask

    task automatic compare_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) stop_on_failure($sformatf("FAIL %s expected %h actual %h", name, exp, act));
    endtask

    task automatic compare_pc(input string name, input pc_t exp, input pc_t act);
        if (act !== exp) stop_on_failure($sformatf("FAIL %s expected %h actual %h", name, exp, act));
    endtask

    task automatic compare_flags(input string name, input flags_t exp, input flags_t act);
        if (act !== exp) stop_on_failure($sformatf("FAIL %s expected %b actual %b", name, exp, act));
    endtask

    function automatic logic chance(int unsigned n);
        return ($urandom % n) == 0;
    endfunction

    // half the time a low register so ports collide often
    function automatic reg_idx_t pick_reg();
        return chance(2) ? reg_idx_t'($urandom % 4) : reg_idx_t'($urandom);
    endfunction

    function automatic word_t pick_word();
        case ($urandom % 10)
            0:       return 32'h0000_0000;
            1:       return 32'hffff_ffff;
            2:       return 32'h7fff_ffff;
            3:       return 32'h8000_0000;
            4:       return 32'h0000_0001;
            default: return $urandom;
        endcase
    endfunction

    function automatic dp_ctrl_t random_ctrl();
        dp_ctrl_t c;
        c = '0;
        c.rf_wr.en                = chance(2);
        c.rf_wr.addr              = pick_reg();
        c.rf_wr.sel_lr            = chance(4);
        c.rf_wr.ldr_en            = chance(3);
        c.rf_wr.ldr_addr          = pick_reg();
        c.rf_wr.ldr_data          = pick_word();
        c.rf_wr.en2               = chance(3);
        c.rf_wr.addr2             = pick_reg();
        c.pc.load                 = chance(4);
        c.pc.sel                  = pc_sel_e'(2'($urandom % 3));
        c.pc.start                = chance(4) ? 11'h7ff : pc_t'($urandom);  // near wrap
        c.operands.a_addr         = pick_reg();
        c.operands.b_addr         = pick_reg();
        c.operands.s_addr         = pick_reg();
        c.operands.str_addr       = pick_reg();
        c.operands.sel_a_in       = fwd_sel_e'(2'($urandom));
        c.operands.sel_b_in       = fwd_sel_e'(2'($urandom));
        c.operands.sel_s_in       = fwd_sel_e'(2'($urandom));
        c.operands.en_a           = chance(2);
        c.operands.en_b           = chance(2);
        c.operands.en_s           = chance(2);
        c.operands.sel_s_reg      = chance(2);
        c.operands.shift_imm      = $urandom % 40;
        c.operands.zero_a         = chance(8);
        c.operands.sel_imm        = chance(4);
        c.operands.sel_branch_imm = chance(2);
        c.operands.imm12          = $urandom & 32'h0000_0fff;
        c.operands.imm24          = $urandom & 32'h00ff_ffff;
        c.shift_op                = shift_op_e'(2'($urandom));
        c.alu_op                  = alu_op_e'(3'($urandom));
        c.en_status               = chance(2);
        c.status_rdy              = chance(2);
        c.sel_post_index          = chance(8);
        return c;
    endfunction

    task automatic check_outputs(input string phase);
        string tag;
        word_t exp_result;
        tag = $sformatf("%s cycle %0d", phase, cycle_no);
        model_eval(ctrl);
        exp_result = ctrl.sel_post_index ? e_val_a : e_alu;
        compare_word($sformatf("%s result", tag), exp_result, result);
        compare_word($sformatf("%s str_data", tag), m_regs[ctrl.operands.str_addr], str_data);
        compare_flags($sformatf("%s flags", tag), m_status, flags_t'(status[31:28]));
        compare_word($sformatf("%s status", tag), {m_status, 28'd0}, status);
        compare_pc($sformatf("%s pc", tag), m_pc, pc);
    endtask

    // drive on the rising edge, check mid cycle, then step the model
    task automatic run_cycle(input string phase, input dp_ctrl_t c, input word_t lr);
        @(posedge clk);
        ctrl  <= c;
        lr_in <= lr;
        @(negedge clk);
        cycle_no++;
        check_outputs(phase);
        model_step(ctrl, lr_in);
    endtask

    task automatic wait_known(input string what);
        int n;
        n = 0;
        while ($isunknown({result, status, str_data, pc}) || arst_n !== 1'b1) begin
            @(posedge clk);
            n++;
            if (n > 20) stop_on_failure($sformatf("timeout: outputs not settled at %s", what));
        end
    endtask

    initial begin
        dp_ctrl_t c;
        void'($urandom(32'h5e11_4031));
        arst_n   = 1'b0;
        ctrl     = '0;
        lr_in    = '0;
        cycle_no = 0;
        model_reset();
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        wait_known("reset release");
        compare_pc("reset pc", '0, pc);
        compare_word("reset status", '0, status);
        compare_word("reset str_data", '0, str_data);

        // each register through A with a zero immediate on B
        for (int i = 0; i < 17; i++) begin
            c                     = '0;
            c.operands.a_addr     = reg_idx_t'(i);
            c.operands.str_addr   = reg_idx_t'(i);
            c.operands.en_a       = (i < 16);
            c.operands.sel_imm    = 1'b1;
            c.alu_op              = ADD;
            run_cycle("reset read", c, '0);
        end

        for (int k = 0; k < 3000; k++) begin
            run_cycle("random", random_ctrl(), pick_word());
        end

        run_cycle("idle", '0, '0);
        wait_known("final idle");
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: source/datapath.sv
`timescale 1ns/100ps

module datapath import arm_isa_pkg::*, dp_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  dp_ctrl_t ctrl,
    input  word_t    lr_in,
    output word_t    result,
    output word_t    status,
    output word_t    str_data,
    output pc_t      pc
);

    operand_ctrl_t op_ctrl;

    // register file side
    word_t    a_data;
    word_t    b_data;
    word_t    s_data;
    word_t    w_data1;
    reg_idx_t w_addr1;
    pc_t      dp_pc;

    // operand path
    word_t  a_in;
    word_t  b_in;
    word_t  s_in;
    word_t  s_next;
    word_t  a_reg;
    word_t  b_reg;
    word_t  s_reg;
    word_t  shift_out;
    word_t  imm;
    word_t  val_a;
    word_t  val_b;
    word_t  alu_y;
    flags_t alu_flags;
    flags_t status_q;

    assign op_ctrl = ctrl.operands;

    // port 1 gets steered to the link register on a call
    assign w_data1 = ctrl.rf_wr.sel_lr ? lr_in : alu_y;
    assign w_addr1 = ctrl.rf_wr.sel_lr ? LR_IDX : ctrl.rf_wr.addr;
    assign dp_pc   = alu_y[10:0];

    regfile u_regfile (
        .clk      (clk),
        .arst_n   (arst_n),
        .w_data1  (w_data1),
        .w_addr1  (w_addr1),
        .w_en1    (ctrl.rf_wr.en),
        .w_data2  (alu_y),
        .w_addr2  (ctrl.rf_wr.addr2),
        .w_en2    (ctrl.rf_wr.en2),
        .ldr_data (ctrl.rf_wr.ldr_data),
        .ldr_addr (ctrl.rf_wr.ldr_addr),
        .ldr_en   (ctrl.rf_wr.ldr_en),
        .pc_ctrl  (ctrl.pc),
        .dp_pc    (dp_pc),
        .a_addr   (op_ctrl.a_addr),
        .b_addr   (op_ctrl.b_addr),
        .s_addr   (op_ctrl.s_addr),
        .str_addr (op_ctrl.str_addr),
        .a_data   (a_data),
        .b_data   (b_data),
        .s_data   (s_data),
        .str_data (str_data),
        .pc       (pc)
    );

    // forwarding muxes in front of A, B and S
    always_comb begin
        case (op_ctrl.sel_a_in)
            FWD_ALU: a_in = alu_y;
            FWD_ALT: a_in = word_t'(pc);
            default: a_in = a_data;
        endcase
        case (op_ctrl.sel_b_in)
            FWD_ALU: b_in = alu_y;
            FWD_ALT: b_in = val_b;      // loops back the current operand
            default: b_in = b_data;
        endcase
        case (op_ctrl.sel_s_in)
            FWD_ALU: s_in = alu_y;
            FWD_ALT: s_in = '0;
            default: s_in = s_data;
        endcase
    end

    assign s_next = op_ctrl.sel_s_reg ? s_in : op_ctrl.shift_imm;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            a_reg <= '0;
            b_reg <= '0;
            s_reg <= '0;
        end else begin
            if (op_ctrl.en_a) a_reg <= a_in;
            if (op_ctrl.en_b) b_reg <= b_in;
            if (op_ctrl.en_s) s_reg <= s_next;
        end
    end

    shifter u_shifter (
        .value   (b_reg),
        .op      (ctrl.shift_op),
        .amount  (s_reg),
        .shifted (shift_out)
    );

    assign imm   = op_ctrl.sel_branch_imm ? op_ctrl.imm24 : op_ctrl.imm12;
    assign val_a = op_ctrl.zero_a ? '0 : a_reg;
    assign val_b = op_ctrl.sel_imm ? imm : shift_out;

    alu u_alu (
        .a     (val_a),
        .b     (val_b),
        .op    (ctrl.alu_op),
        .y     (alu_y),
        .flags (alu_flags)
    );

    // flags only latch when the controller says they are valid
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            status_q <= '0;
        end else if (ctrl.en_status && ctrl.status_rdy) begin
            status_q <= alu_flags;
        end
    end

    assign status = {status_q, 28'd0};     // NZCV in 31:28
    assign result = ctrl.sel_post_index ? val_a : alu_y;  // post-index passes base

endmodule

// File: source/alu.sv
`timescale 1ns/100ps

module alu import arm_isa_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_e op,
    output word_t   y,
    output flags_t  flags
);

    word_t       add_x;
    word_t       add_y;
    logic        add_cin;
    logic [32:0] sum;
    logic        arith;

    // subtraction as x + ~y + 1 so carry out means no borrow
    always_comb begin
        add_x   = a;
        add_y   = b;
        add_cin = 1'b0;
        case (op)
            SUB: begin
                add_y   = ~b;
                add_cin = 1'b1;
            end
            RSB: begin
                add_x   = b;
                add_y   = ~a;
                add_cin = 1'b1;
            end
            default: ;
        endcase
    end

    assign sum   = {1'b0, add_x} + {1'b0, add_y} + 33'(add_cin);
    assign arith = (op == ADD) || (op == SUB) || (op == RSB);

    always_comb begin
        case (op)
            AND:     y = a & b;
            ORR:     y = a | b;
            EOR:     y = a ^ b;
            MOV:     y = b;
            MVN:     y = ~b;
            default: y = sum[31:0];     // ADD, SUB, RSB
        endcase
    end

    assign flags.n = y[31];
    assign flags.z = (y == '0);
    assign flags.c = arith & sum[32];
    // same-sign inputs, result sign differs
    assign flags.v = arith & (add_x[31] == add_y[31]) & (sum[31] != add_x[31]);

endmodule

// File: source/shifter.sv
`timescale 1ns/100ps

module shifter import arm_isa_pkg::*; (
    input  word_t     value,
    input  shift_op_e op,
    input  word_t     amount,
    output word_t     shifted
);

    logic [4:0]  amt;
    logic [63:0] rot;

    assign amt = amount[4:0];   // only 0..31 matters

    // rotate by shifting a doubled copy, amt of 0 leaves value as is
    assign rot = {value, value} >> amt;

    always_comb begin
        case (op)
            LSL:     shifted = value << amt;
            LSR:     shifted = value >> amt;
            ASR:     shifted = word_t'($signed(value) >>> amt);  // sign fill
            ROR:     shifted = rot[31:0];
            default: shifted = value;
        endcase
    end

endmodule

// File: source/regfile.sv
`timescale 1ns/100ps

module regfile import arm_isa_pkg::*, dp_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  word_t    w_data1,
    input  reg_idx_t w_addr1,
    input  logic     w_en1,
    input  word_t    w_data2,
    input  reg_idx_t w_addr2,
    input  logic     w_en2,
    input  word_t    ldr_data,
    input  reg_idx_t ldr_addr,
    input  logic     ldr_en,
    input  pc_ctrl_t pc_ctrl,
    input  pc_t      dp_pc,
    input  reg_idx_t a_addr,
    input  reg_idx_t b_addr,
    input  reg_idx_t s_addr,
    input  reg_idx_t str_addr,
    output word_t    a_data,
    output word_t    b_data,
    output word_t    s_data,
    output word_t    str_data,
    output pc_t      pc
);

    word_t regs [16];
    pc_t   pc_q;

    // later writes win: ldr over port 2 over port 1
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (w_en1) regs[w_addr1] <= w_data1;
            if (w_en2) regs[w_addr2] <= w_data2;
            if (ldr_en) regs[ldr_addr] <= ldr_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q <= '0;
        end else if (pc_ctrl.load) begin
            case (pc_ctrl.sel)
                PC_NEXT:  pc_q <= pc_q + 11'd1;    // wraps naturally
                PC_ALU:   pc_q <= dp_pc;
                PC_START: pc_q <= pc_ctrl.start;
                default:  pc_q <= pc_q;            // unused select, hold
            endcase
        end
    end

    // reads see old contents until the edge
    assign a_data   = regs[a_addr];
    assign b_data   = regs[b_addr];
    assign s_data   = regs[s_addr];
    assign str_data = regs[str_addr];
    assign pc       = pc_q;

endmodule

// File: source/dp_ctrl_pkg.sv
package dp_ctrl_pkg;
    import arm_isa_pkg::*;

    // operand forwarding; ZERO_OR_RF reads the register file like RF
    typedef enum logic [1:0] {
        FWD_RF         = 2'b00,
        FWD_ALU        = 2'b01,
        FWD_ZERO_OR_RF = 2'b10,
        FWD_ALT        = 2'b11     // pc for A, val_b for B, zero for S
    } fwd_sel_e;

    typedef enum logic [1:0] {
        PC_NEXT  = 2'b00,
        PC_ALU   = 2'b01,
        PC_START = 2'b10
    } pc_sel_e;

    typedef struct packed {
        logic     en;         // port 1, alu result or lr_in
        reg_idx_t addr;
        logic     sel_lr;     // steer lr_in into r14
        logic     ldr_en;     // load port
        reg_idx_t ldr_addr;
        word_t    ldr_data;
        logic     en2;        // port 2, alu result
        reg_idx_t addr2;
    } rf_wr_t;

    typedef struct packed {
        logic    load;
        pc_sel_e sel;
        pc_t     start;
    } pc_ctrl_t;

    typedef struct packed {
        reg_idx_t a_addr;
        reg_idx_t b_addr;
        reg_idx_t s_addr;
        reg_idx_t str_addr;
        fwd_sel_e sel_a_in;
        fwd_sel_e sel_b_in;
        fwd_sel_e sel_s_in;
        logic     en_a;
        logic     en_b;
        logic     en_s;
        logic     sel_s_reg;       // 1: forwarded S input, 0: shift_imm
        word_t    shift_imm;
        logic     zero_a;
        logic     sel_imm;         // immediate instead of shifter output
        logic     sel_branch_imm;  // imm24 instead of imm12
        word_t    imm12;
        word_t    imm24;
    } operand_ctrl_t;

    typedef struct packed {
        rf_wr_t        rf_wr;
        pc_ctrl_t      pc;
        operand_ctrl_t operands;
        shift_op_e     shift_op;
        alu_op_e       alu_op;
        logic          en_status;
        logic          status_rdy;
        logic          sel_post_index;  // result = val_a
    } dp_ctrl_t;

endpackage

// File: source/arm_isa_pkg.sv
package arm_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [10:0] pc_t;      // word address, wraps at 2047

    localparam reg_idx_t LR_IDX = 4'd14;    // link register

    // alu operations, b side is the shifter or immediate
    typedef enum logic [2:0] {
        ADD = 3'd0,     // a + b
        SUB = 3'd1,     // a - b
        RSB = 3'd2,     // b - a
        AND = 3'd3,
        ORR = 3'd4,
        EOR = 3'd5,
        MOV = 3'd6,     // b
        MVN = 3'd7      // ~b
    } alu_op_e;

    // barrel shifter ops, amount is the low 5 bits of S
    typedef enum logic [1:0] {
        LSL = 2'd0,
        LSR = 2'd1,
        ASR = 2'd2,
        ROR = 2'd3
    } shift_op_e;

    // c is not-borrow on subtract, c and v are 0 for logic ops
    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

endpackage
